//--- compile.f
verilog/red_pkg.sv
verilog/red_in_fifo.sv
verilog/red_sync.sv
verilog/red_arbiter.sv
verilog/red_out_reg.sv
verilog/red_top.sv
sim/tb_red_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the reduction stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_red_top
LOG_FILE=sim.log
PASS_TEXT="Verification passed"

verilator --binary --timing --assert -f compile.f --top-module tb_red_top \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^$PASS_TEXT\$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

//--- sim/tb_red_top.sv
/* Random reductions checked against a tag-indexed model. At most 32 reductions are in
   flight, so tags stay unique; stimulus comes from a Galois LFSR with a fixed seed */
`timescale 1ns/10ps

module tb_red_top;

  localparam int          num_red        = 300;
  localparam int          max_in_flight  = 32;
  localparam int          clk_half       = 20;
  localparam int          clk_period     = 40;
  localparam int          reset_cycles   = 10;
  localparam int          cycles_per_red = 40;
  localparam int          quiet_cycles   = 4;
  localparam logic [31:0] lfsr_seed      = 32'd77880;
  localparam logic [31:0] lfsr_taps      = 32'hB4BC_D35C;

  logic                                         clk_i;
  logic                                         rst_n_i;
  logic [red_pkg::num_routes-1:0]               in_valid_i;
  logic [red_pkg::num_routes-1:0]               in_ready_o;
  red_pkg::red_flit_t [red_pkg::num_routes-1:0] in_flit_i;
  logic                                         out_valid_o;
  logic                                         out_ready_i;
  red_pkg::red_flit_t                           out_flit_o;

  // Model state
  logic [31:0]                    lfsr_q;
  red_pkg::red_flit_t             route_q [red_pkg::num_routes][$];
  red_pkg::red_flit_t             expected_by_tag [int];
  logic [red_pkg::num_routes-1:0] in_taken;
  logic                           hold_seen;
  red_pkg::red_flit_t             hold_flit;
  int                             issued;
  int                             received;

  red_top dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_flit_i   (in_flit_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_flit_o  (out_flit_o)
  );

  always #clk_half clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // One LFSR step per bit with the newest bit in bit 0
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ lfsr_taps) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  function automatic string op_name(input red_pkg::red_op_e op);
    case (op)
      red_pkg::red_lsb_and:   return "lsb_and";
      red_pkg::red_collect_b: return "collect_b";
      default:                return "forward";
    endcase
  endfunction

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
    $display("Verification failed");
    $fatal(1, "value mismatch in %s", test);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  // Draws one reduction, queues its flits per route and stores the expected result
  task automatic issue_reduction();
    red_pkg::red_hdr_t  hdr;
    red_pkg::red_flit_t part [red_pkg::num_routes];
    red_pkg::red_flit_t exp;
    red_pkg::resp_e     resp;
    logic [31:0]        r;
    logic               lsb;
    logic               found;
    int                 sel;
    hdr.tag = issued[7:0];
    hdr.src_mask = '0;
    while (hdr.src_mask == '0) begin
      r = random_bits(4);
      hdr.src_mask = r[3:0];
    end
    r = random_bits(2);
    case (r[1:0])
      2'd1:    hdr.op = red_pkg::red_lsb_and;
      2'd2:    hdr.op = red_pkg::red_collect_b;
      default: hdr.op = red_pkg::red_forward;
    endcase
    sel = 0;
    for (int i = 0; i < red_pkg::num_routes; i++) begin
      part[i] = '0;
      part[i].hdr = hdr;
      if (hdr.src_mask[i]) begin
        if (hdr.op == red_pkg::red_collect_b) begin
          // Slave error one time in four
          r = random_bits(2);
          case (r[1:0])
            2'd0:    resp = red_pkg::resp_slverr;
            2'd1:    resp = red_pkg::resp_okay;
            2'd2:    resp = red_pkg::resp_exokay;
            default: resp = red_pkg::resp_decerr;
          endcase
          r = random_bits(30);
          part[i].payload.b.user = r[29:0];
          part[i].payload.b.resp = resp;
        end else begin
          part[i].payload.w.data = random_bits(32);
        end
        route_q[i].push_back(part[i]);
      end
    end
    // Lowest participant is the selected route
    for (int i = red_pkg::num_routes - 1; i >= 0; i--) begin
      if (hdr.src_mask[i]) sel = i;
    end
    exp = part[sel];
    if (hdr.op == red_pkg::red_lsb_and) begin
      lsb = 1'b1;
      for (int i = 0; i < red_pkg::num_routes; i++) begin
        if (hdr.src_mask[i]) lsb = lsb & part[i].payload.w.data[0];
      end
      exp.payload.w.data[0] = lsb;
    end else if (hdr.op == red_pkg::red_collect_b) begin
      found = 1'b0;
      for (int i = 0; i < red_pkg::num_routes; i++) begin
        if (!found && hdr.src_mask[i] &&
            part[i].payload.b.resp == red_pkg::resp_slverr) begin
          exp   = part[i];
          found = 1'b1;
        end
      end
    end
    expected_by_tag[int'(hdr.tag)] = exp;
    issued++;
  endtask

  // ------------------------------------------------------------
  // Stimulus driven on the rising edge
  // ------------------------------------------------------------
  always @(posedge clk_i) begin : drive_inputs
    logic [31:0] r;
    if (rst_n_i) begin
      // Flits accepted on this edge leave the route queues
      for (int i = 0; i < red_pkg::num_routes; i++) begin
        if (in_taken[i]) void'(route_q[i].pop_front());
      end
      if (issued < num_red && (issued - received) < max_in_flight) issue_reduction();
      for (int i = 0; i < red_pkg::num_routes; i++) begin
        // A raised valid stays until the flit is taken
        if (!(in_valid_i[i] && !in_taken[i])) begin
          r = random_bits(1);
          if (route_q[i].size() > 0 && r[0]) begin
            in_valid_i[i] <= 1'b1;
            in_flit_i[i]  <= route_q[i][0];
          end else begin
            in_valid_i[i] <= 1'b0;
          end
        end
      end
      // Back-pressure about 30 percent of cycles
      r = random_bits(4);
      out_ready_i <= (r[3:0] >= 4'd5);
    end
  end

  // ------------------------------------------------------------
  // Monitor and scoreboard sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge clk_i) begin : check_outputs
    red_pkg::red_flit_t exp;
    int                 tag;
    if (rst_n_i) begin
      in_taken = in_valid_i & in_ready_o;
      // Stalled output must hold
      if (hold_seen) begin
        assert (out_valid_o) else abort_run("out_valid_o dropped while the output was stalled");
        assert (out_flit_o == hold_flit) else begin
          report_mismatch("backpressure_stable", 64'(hold_flit), 64'(out_flit_o));
        end
      end
      hold_seen = out_valid_o && !out_ready_i;
      hold_flit = out_flit_o;
      if (out_valid_o && out_ready_i) begin
        tag = int'(out_flit_o.hdr.tag);
        assert (expected_by_tag.exists(tag)) else begin
          abort_run($sformatf("Output tag %0d was not expected", tag));
        end
        exp = expected_by_tag[tag];
        assert (out_flit_o == exp) else begin
          report_mismatch(op_name(exp.hdr.op), 64'(exp), 64'(out_flit_o));
        end
        expected_by_tag.delete(tag);
        received++;
      end
    end
  end

  // Reset, idle state check, then wait for all results
  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    in_valid_i  = '0;
    in_flit_i   = '0;
    out_ready_i = 1'b0;
    lfsr_q      = lfsr_seed;
    issued      = 0;
    received    = 0;
    in_taken    = '0;
    hold_seen   = 1'b0;
    hold_flit   = '0;
    repeat (reset_cycles) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o) else report_mismatch("reset_state", 64'd0, 64'(out_valid_o));
    assert (in_ready_o == '1) else begin
      report_mismatch("reset_state", 64'hf, 64'(in_ready_o));
    end
    wait (received == num_red);
    // A duplicate result would reach the output within a few cycles
    repeat (quiet_cycles) @(negedge clk_i);
    assert (!out_valid_o) else begin
      abort_run("Output still valid after every reduction was received");
    end
    $display("Verification passed");
    $finish;
  end

  // Watchdog allowing 40 cycles per reduction
  initial begin
    #(num_red * cycles_per_red * clk_period);
    $display("Timeout: only %0d of %0d reductions completed", received, num_red);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verilog/red_arbiter.sv
/* Combines the head flits of one complete reduction and pops all participants at once.
   Purely combinational; the output must be registered downstream */
`timescale 1ns/10ps

module red_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Heads of the input FIFOs
  input  logic [red_pkg::num_routes-1:0]              valid_i,
  output logic [red_pkg::num_routes-1:0]              ready_o,
  input  red_pkg::red_flit_t [red_pkg::num_routes-1:0] data_i,
  // Reduced flit
  output logic                                        valid_o,
  input  logic                                        ready_i,
  output red_pkg::red_flit_t                          data_o
);

  logic                             complete;
  logic [red_pkg::route_idx_w-1:0]  sel;
  logic [red_pkg::num_routes-1:0]   route_mask;

  red_pkg::red_flit_t sel_flit;
  red_pkg::red_flit_t lsb_flit;
  red_pkg::red_flit_t collect_flit;
  logic               lsb;

  // Tag-matched selection
  red_sync u_sync (
    .clk_i        (clk_i),
    .valid_i      (valid_i),
    .flit_i       (data_i),
    .complete_o   (complete),
    .sel_o        (sel),
    .route_mask_o (route_mask)
  );

  assign sel_flit = data_i[sel];

  // ------------------------------------------------------------
  // Operations, all computed in parallel
  // ------------------------------------------------------------

  // AND of data bit 0 over participants, placed into the selected flit
  always_comb begin
    lsb = 1'b1;
    for (int i = 0; i < red_pkg::num_routes; i++) begin
      if (route_mask[i]) lsb &= data_i[i].payload.w.data[0];
    end
    lsb_flit                     = sel_flit;
    lsb_flit.payload.w.data[0]   = lsb;
  end

  // First participant reporting a slave error, else the selected flit
  always_comb begin
    collect_flit = sel_flit;
    // Downward scan leaves the lowest match
    for (int i = red_pkg::num_routes - 1; i >= 0; i--) begin
      if (route_mask[i] && (data_i[i].payload.b.resp == red_pkg::resp_slverr)) begin
        collect_flit = data_i[i];
      end
    end
  end

  // Result select by the op of the selected head
  always_comb begin
    case (sel_flit.hdr.op)
      red_pkg::red_forward:   data_o = sel_flit;
      red_pkg::red_lsb_and:   data_o = lsb_flit;
      red_pkg::red_collect_b: data_o = collect_flit;
      default:                data_o = sel_flit;
    endcase
  end

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------
  assign valid_o = complete;

  // All participants leave on the same edge the result is taken
  assign ready_o = (valid_o && ready_i) ? route_mask : '0;

  // A pop always hits a valid head
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ready_o & ~valid_i) == '0);

endmodule

//--- verilog/red_in_fifo.sv
/* Two-entry input buffer for one route; no bypass, so an item is at the head one cycle
   after it is accepted */
`timescale 1ns/10ps

module red_in_fifo (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Upstream side
  input  logic               valid_i,
  output logic               ready_o,
  input  red_pkg::red_flit_t flit_i,
  // Head of the queue towards the arbiter
  output logic               valid_o,
  input  logic               ready_i,
  output red_pkg::red_flit_t flit_o
);

  // Two flit slots addressed by the pointers
  red_pkg::red_flit_t mem_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready while fewer than two items are held
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign flit_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Pointers and fill count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= flit_i;
  end

  // Count stays in range and matches the pointer distance
  // The arbiter never asks an empty FIFO for its head
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q != 2'd3) && ((count_q == 2'd1) == (wr_ptr_q != rd_ptr_q)) &&
    !((count_q == 2'd0) && ready_i));

endmodule

//--- verilog/red_out_reg.sv
/* Two-entry spill register, full throughput, output flit stable under back-pressure */
`timescale 1ns/10ps

module red_out_reg (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  output logic               ready_o,
  input  red_pkg::red_flit_t flit_i,
  output logic               valid_o,
  input  logic               ready_i,
  output red_pkg::red_flit_t flit_o
);

  // Stage a takes new items, stage b holds the spill
  red_pkg::red_flit_t a_data_q;
  red_pkg::red_flit_t b_data_q;
  logic               a_full_q;
  logic               b_full_q;
  logic               a_fill;
  logic               a_drain;
  logic               b_fill;
  logic               b_drain;

  assign ready_o = ~a_full_q | ~b_full_q;
  assign a_fill  = valid_i & ready_o;
  // a moves on whenever b is free
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= flit_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // b is older than a, so it goes first
  assign valid_o = a_full_q | b_full_q;
  assign flit_o  = b_full_q ? b_data_q : a_data_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(flit_o)));

endmodule

//--- verilog/red_pkg.sv
/* Shared sizes and flit layout for the reduction stage. The payload word is read as W data
   or as a B response depending on the operation; routes are limited to four */
package red_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int unsigned num_routes  = 4;
  localparam int unsigned route_idx_w = 2;
  localparam int unsigned data_w      = 32;
  localparam int unsigned tag_w       = 8;

  // Collective operation carried in the header
  typedef enum logic [1:0] {
    red_forward   = 2'd0,
    red_lsb_and   = 2'd1,
    red_collect_b = 2'd2
  } red_op_e;

  // AXI style response codes
  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_exokay = 2'd1,
    resp_slverr = 2'd2,
    resp_decerr = 2'd3
  } resp_e;

  // Header, 14 bits
  typedef struct packed {
    red_op_e                 op;
    logic [tag_w-1:0]        tag;
    // One bit per route that takes part in the reduction
    logic [num_routes-1:0]   src_mask;
  } red_hdr_t;

  // W view of the payload
  typedef struct packed {
    logic [data_w-1:0] data;
  } red_w_t;

  // B view, resp sits in the low two bits
  typedef struct packed {
    logic [data_w-3:0] user;
    resp_e             resp;
  } red_b_t;

  typedef union packed {
    red_w_t w;
    red_b_t b;
  } red_payload_u;

  // Full flit, 46 bits
  typedef struct packed {
    red_hdr_t     hdr;
    red_payload_u payload;
  } red_flit_t;

endpackage

//--- verilog/red_sync.sv
/* Picks the lowest route whose reduction is complete, matched by tag. Ops of the
   participants are assumed equal, only checked by assertion */
`timescale 1ns/10ps

module red_sync (
  // Only used by the assertion
  input  logic                                        clk_i,
  input  logic [red_pkg::num_routes-1:0]              valid_i,
  input  red_pkg::red_flit_t [red_pkg::num_routes-1:0] flit_i,
  output logic                                        complete_o,
  output logic [red_pkg::route_idx_w-1:0]             sel_o,
  output logic [red_pkg::num_routes-1:0]              route_mask_o
);

  logic [red_pkg::num_routes-1:0] route_done;
  logic                           op_agree;

  // ------------------------------------------------------------
  // Completion per route
  // ------------------------------------------------------------
  always_comb begin
    logic [red_pkg::num_routes-1:0] mask;
    logic                           ok;
    route_done = '0;
    for (int i = 0; i < red_pkg::num_routes; i++) begin
      mask = flit_i[i].hdr.src_mask;
      // Own head valid, self listed, all listed heads present
      ok = valid_i[i] & mask[i] & ((valid_i & mask) == mask);
      // Listed heads must belong to the same reduction
      for (int j = 0; j < red_pkg::num_routes; j++) begin
        if (mask[j] && (flit_i[j].hdr.tag != flit_i[i].hdr.tag)) ok = 1'b0;
      end
      route_done[i] = ok;
    end
  end

  // Lowest complete route wins; scan from the top so the last hit is the lowest
  always_comb begin
    sel_o      = '0;
    complete_o = 1'b0;
    for (int i = red_pkg::num_routes - 1; i >= 0; i--) begin
      if (route_done[i]) begin
        sel_o      = i[red_pkg::route_idx_w-1:0];
        complete_o = 1'b1;
      end
    end
  end

  assign route_mask_o = complete_o ? flit_i[sel_o].hdr.src_mask : '0;

  // Participants of one reduction must all carry the same op
  always_comb begin
    op_agree = 1'b1;
    for (int i = 0; i < red_pkg::num_routes; i++) begin
      if (route_mask_o[i] && (flit_i[i].hdr.op != flit_i[sel_o].hdr.op)) op_agree = 1'b0;
    end
  end

  assert property (@(posedge clk_i) complete_o |-> op_agree);

endmodule

//--- verilog/red_top.sv
/* Reduction stage top: four buffered routes, combine, registered output. Latency from the
   last participant to the output is two cycles minimum */
`timescale 1ns/10ps

module red_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Input routes
  input  logic [red_pkg::num_routes-1:0]              in_valid_i,
  output logic [red_pkg::num_routes-1:0]              in_ready_o,
  input  red_pkg::red_flit_t [red_pkg::num_routes-1:0] in_flit_i,
  // Reduced output
  output logic                                        out_valid_o,
  input  logic                                        out_ready_i,
  output red_pkg::red_flit_t                          out_flit_o
);

  logic [red_pkg::num_routes-1:0]              head_valid;
  logic [red_pkg::num_routes-1:0]              pop;
  red_pkg::red_flit_t [red_pkg::num_routes-1:0] head_flit;

  logic               red_valid;
  logic               red_ready;
  red_pkg::red_flit_t red_flit;

  // ------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------
  for (genvar i = 0; i < red_pkg::num_routes; i++) begin : g_route
    red_in_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (in_valid_i[i]),
      .ready_o (in_ready_o[i]),
      .flit_i  (in_flit_i[i]),
      .valid_o (head_valid[i]),
      .ready_i (pop[i]),
      .flit_o  (head_flit[i])
    );
  end

  // Sync and combine
  red_arbiter u_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (head_valid),
    .ready_o (pop),
    .data_i  (head_flit),
    .valid_o (red_valid),
    .ready_i (red_ready),
    .data_o  (red_flit)
  );

  // Output side
  red_out_reg u_out (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (red_valid),
    .ready_o (red_ready),
    .flit_i  (red_flit),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .flit_o  (out_flit_o)
  );

endmodule
